// File: cpu_pkg.sv
package cpu_pkg;

    // machine word and general register geometry
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // csr number and exception code widths
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

endpackage

// File: csr_pkg.sv
package csr_pkg;

    import cpu_pkg::*;

    // csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;

    // crmd fields
    localparam int crmd_plv_lsb = 0;
    localparam int crmd_plv_msb = 1;
    localparam int crmd_ie      = 2;
    localparam int crmd_da      = 3;

    // prmd fields
    localparam int prmd_pplv_lsb = 0;
    localparam int prmd_pplv_msb = 1;
    localparam int prmd_pie      = 2;

    // estat fields, only is_sw is software writable
    localparam int estat_is_sw_lsb    = 0;
    localparam int estat_is_sw_msb    = 1;
    localparam int estat_ecode_lsb    = 16;
    localparam int estat_ecode_msb    = 21;
    localparam int estat_esubcode_lsb = 22;
    localparam int estat_esubcode_msb = 30;

    // eentry holds a 64-byte aligned vector
    localparam int eentry_va_lsb = 6;
    localparam int eentry_va_msb = 31;

    // direct address mode out of reset
    localparam logic [xlen-1:0] crmd_reset = xlen'(1) << crmd_da;

    localparam logic [ecode_w-1:0] ecode_sys = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine = 6'h0d;

endpackage

// File: csr.sv
module csr import cpu_pkg::*, csr_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [csr_num_w-1:0]  csr_num,
    input  logic                  csr_we,
    input  logic [xlen-1:0]       csr_wmask,
    input  logic [xlen-1:0]       csr_wvalue,
    input  logic                  ertn_valid,
    input  logic                  excep_valid,
    input  logic [ecode_w-1:0]    ecode,
    input  logic [esubcode_w-1:0] esubcode,
    input  logic [xlen-1:0]       wb_pc,
    output logic [xlen-1:0]       csr_rvalue,
    output logic [xlen-1:0]       ex_entry,
    output logic [xlen-1:0]       era_value
);

    logic [crmd_plv_msb:crmd_plv_lsb]             crmd_plv_q;
    logic                                         crmd_ie_q;
    logic                                         crmd_da_q;
    logic [prmd_pplv_msb:prmd_pplv_lsb]           prmd_pplv_q;
    logic                                         prmd_pie_q;
    logic [estat_is_sw_msb:estat_is_sw_lsb]       estat_is_q;
    logic [ecode_w-1:0]                           estat_ecode_q;
    logic [esubcode_w-1:0]                        estat_esubcode_q;
    logic [xlen-1:0]                              era_q;
    logic [eentry_va_msb:eentry_va_lsb]           eentry_va_q;
    logic [xlen-1:0]                              save_q [4];

    logic [xlen-1:0] csr_wdata;
    logic            wr_crmd;
    logic            wr_prmd;
    logic            wr_estat;
    logic            wr_era;
    logic            wr_eentry;
    logic [3:0]      wr_save;

    // read mux, unmodeled numbers return zero
    always_comb begin
        csr_rvalue = '0;
        case (csr_num)
            csr_crmd: begin
                csr_rvalue[crmd_plv_msb:crmd_plv_lsb] = crmd_plv_q;
                csr_rvalue[crmd_ie]                   = crmd_ie_q;
                csr_rvalue[crmd_da]                   = crmd_da_q;
            end
            csr_prmd: begin
                csr_rvalue[prmd_pplv_msb:prmd_pplv_lsb] = prmd_pplv_q;
                csr_rvalue[prmd_pie]                    = prmd_pie_q;
            end
            csr_estat: begin
                csr_rvalue[estat_is_sw_msb:estat_is_sw_lsb]       = estat_is_q;
                csr_rvalue[estat_ecode_msb:estat_ecode_lsb]       = estat_ecode_q;
                csr_rvalue[estat_esubcode_msb:estat_esubcode_lsb] = estat_esubcode_q;
            end
            csr_era:    csr_rvalue = era_q;
            csr_eentry: csr_rvalue[eentry_va_msb:eentry_va_lsb] = eentry_va_q;
            csr_save0:  csr_rvalue = save_q[0];
            csr_save1:  csr_rvalue = save_q[1];
            csr_save2:  csr_rvalue = save_q[2];
            csr_save3:  csr_rvalue = save_q[3];
            default: ;
        endcase
    end

    // merge new bits under the mask into the current value
    assign csr_wdata = (csr_rvalue & ~csr_wmask) | (csr_wvalue & csr_wmask);

    assign wr_crmd    = csr_we && (csr_num == csr_crmd);
    assign wr_prmd    = csr_we && (csr_num == csr_prmd);
    assign wr_estat   = csr_we && (csr_num == csr_estat);
    assign wr_era     = csr_we && (csr_num == csr_era);
    assign wr_eentry  = csr_we && (csr_num == csr_eentry);
    assign wr_save[0] = csr_we && (csr_num == csr_save0);
    assign wr_save[1] = csr_we && (csr_num == csr_save1);
    assign wr_save[2] = csr_we && (csr_num == csr_save2);
    assign wr_save[3] = csr_we && (csr_num == csr_save3);

    // exception entry wins over ertn
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv_q <= crmd_reset[crmd_plv_msb:crmd_plv_lsb];
            crmd_ie_q  <= crmd_reset[crmd_ie];
            crmd_da_q  <= crmd_reset[crmd_da];
        end else if (excep_valid) begin
            crmd_plv_q <= '0;
            crmd_ie_q  <= 1'b0;
        end else if (ertn_valid) begin
            crmd_plv_q <= prmd_pplv_q;
            crmd_ie_q  <= prmd_pie_q;
        end else if (wr_crmd) begin
            crmd_plv_q <= csr_wdata[crmd_plv_msb:crmd_plv_lsb];
            crmd_ie_q  <= csr_wdata[crmd_ie];
            crmd_da_q  <= csr_wdata[crmd_da];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv_q <= '0;
            prmd_pie_q  <= 1'b0;
        end else if (excep_valid) begin
            prmd_pplv_q <= crmd_plv_q;
            prmd_pie_q  <= crmd_ie_q;
        end else if (wr_prmd) begin
            prmd_pplv_q <= csr_wdata[prmd_pplv_msb:prmd_pplv_lsb];
            prmd_pie_q  <= csr_wdata[prmd_pie];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is_q       <= '0;
            estat_ecode_q    <= '0;
            estat_esubcode_q <= '0;
        end else if (excep_valid) begin
            estat_ecode_q    <= ecode;
            estat_esubcode_q <= esubcode;
        end else if (wr_estat) begin
            estat_is_q <= csr_wdata[estat_is_sw_msb:estat_is_sw_lsb];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era_q <= '0;
        end else if (excep_valid) begin
            era_q <= wb_pc;
        end else if (wr_era) begin
            era_q <= csr_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va_q <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            if (wr_eentry) begin
                eentry_va_q <= csr_wdata[eentry_va_msb:eentry_va_lsb];
            end
            for (int i = 0; i < 4; i++) begin
                if (wr_save[i]) begin
                    save_q[i] <= csr_wdata;
                end
            end
        end
    end

    assign ex_entry  = {eentry_va_q, {eentry_va_lsb{1'b0}}};
    assign era_value = era_q;

endmodule

// File: regfile.sv
module regfile import cpu_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    // contents start out zero
    logic [xlen-1:0] regs [reg_count] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, no write-through
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// File: wb_stage.sv
module wb_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mem_to_wb_valid,
    input  logic                  mem_rf_we,
    input  logic [reg_addr_w-1:0] mem_rf_waddr,
    input  logic [xlen-1:0]       mem_rf_result,
    input  logic [xlen-1:0]       mem_pc,
    input  logic                  mem_res_from_csr,
    input  logic [csr_num_w-1:0]  mem_csr_num,
    input  logic                  mem_csr_we,
    input  logic [xlen-1:0]       mem_csr_wmask,
    input  logic [xlen-1:0]       mem_csr_wvalue,
    input  logic                  mem_ertn,
    input  logic                  mem_excep,
    input  logic [ecode_w-1:0]    mem_ecode,
    input  logic [esubcode_w-1:0] mem_esubcode,
    output logic                  wb_allowin,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic                  wb_flush,
    output logic [xlen-1:0]       flush_target,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic                  wb_valid;
    logic                  wb_rf_we;
    logic [reg_addr_w-1:0] wb_rf_waddr;
    logic [xlen-1:0]       wb_rf_result;
    logic [xlen-1:0]       wb_pc;
    logic                  wb_res_from_csr;
    logic [csr_num_w-1:0]  wb_csr_num;
    logic                  wb_csr_we;
    logic [xlen-1:0]       wb_csr_wmask;
    logic [xlen-1:0]       wb_csr_wvalue;
    logic                  wb_ertn;
    logic                  wb_excep;
    logic [ecode_w-1:0]    wb_ecode;
    logic [esubcode_w-1:0] wb_esubcode;

    logic            csr_we;
    logic            ertn_valid;
    logic            excep_valid;
    logic [xlen-1:0] csr_rvalue;
    logic [xlen-1:0] ex_entry;
    logic [xlen-1:0] era_value;

    // retires every cycle
    assign wb_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_rf_we        <= mem_rf_we;
            wb_rf_waddr     <= mem_rf_waddr;
            wb_rf_result    <= mem_rf_result;
            wb_pc           <= mem_pc;
            wb_res_from_csr <= mem_res_from_csr;
            wb_csr_num      <= mem_csr_num;
            wb_csr_we       <= mem_csr_we;
            wb_csr_wmask    <= mem_csr_wmask;
            wb_csr_wvalue   <= mem_csr_wvalue;
            wb_ertn         <= mem_ertn;
            wb_excep        <= mem_excep;
            wb_ecode        <= mem_ecode;
            wb_esubcode     <= mem_esubcode;
        end
    end

    assign excep_valid = wb_valid && wb_excep;
    assign ertn_valid  = wb_valid && wb_ertn;

    // a faulting instruction commits nothing
    assign rf_we    = wb_valid && wb_rf_we && !wb_excep;
    assign csr_we   = wb_valid && wb_csr_we && !wb_excep;
    assign rf_waddr = wb_rf_waddr;
    assign rf_wdata = wb_res_from_csr ? csr_rvalue : wb_rf_result;

    csr csr_inst (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (wb_csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (wb_csr_wmask),
        .csr_wvalue  (wb_csr_wvalue),
        .ertn_valid  (ertn_valid),
        .excep_valid (excep_valid),
        .ecode       (wb_ecode),
        .esubcode    (wb_esubcode),
        .wb_pc       (wb_pc),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .era_value   (era_value)
    );

    assign wb_flush     = excep_valid || ertn_valid;
    assign flush_target = excep_valid ? ex_entry : era_value;

    // trace port
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: wb_subsystem.sv
module wb_subsystem import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mem_to_wb_valid,
    input  logic                  mem_rf_we,
    input  logic [reg_addr_w-1:0] mem_rf_waddr,
    input  logic [xlen-1:0]       mem_rf_result,
    input  logic [xlen-1:0]       mem_pc,
    input  logic                  mem_res_from_csr,
    input  logic [csr_num_w-1:0]  mem_csr_num,
    input  logic                  mem_csr_we,
    input  logic [xlen-1:0]       mem_csr_wmask,
    input  logic [xlen-1:0]       mem_csr_wvalue,
    input  logic                  mem_ertn,
    input  logic                  mem_excep,
    input  logic [ecode_w-1:0]    mem_ecode,
    input  logic [esubcode_w-1:0] mem_esubcode,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic                  wb_allowin,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    output logic                  wb_flush,
    output logic [xlen-1:0]       flush_target,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    wb_stage wb_stage_inst (
        .clk               (clk),
        .resetn            (resetn),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_result     (mem_rf_result),
        .mem_pc            (mem_pc),
        .mem_res_from_csr  (mem_res_from_csr),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_we        (mem_csr_we),
        .mem_csr_wmask     (mem_csr_wmask),
        .mem_csr_wvalue    (mem_csr_wvalue),
        .mem_ertn          (mem_ertn),
        .mem_excep         (mem_excep),
        .mem_ecode         (mem_ecode),
        .mem_esubcode      (mem_esubcode),
        .wb_allowin        (wb_allowin),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .wb_flush          (wb_flush),
        .flush_target      (flush_target),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

// File: tb_wb_subsystem.sv
module tb_wb_subsystem import cpu_pkg::*, csr_pkg::*; ();

    localparam int phase_count   = 5;
    localparam int phase_len     = 200;
    localparam int timeout_limit = phase_count * phase_len + 50;

    typedef struct {
        logic                  valid;
        logic                  rf_we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       pc;
        logic                  res_from_csr;
        logic [csr_num_w-1:0]  csr_num;
        logic                  csr_we;
        logic [xlen-1:0]       wmask;
        logic [xlen-1:0]       wvalue;
        logic                  ertn;
        logic                  excep;
        logic [ecode_w-1:0]    ecode;
        logic [esubcode_w-1:0] esubcode;
    } instr_t;

    logic                  clk, resetn, mem_to_wb_valid, mem_rf_we, mem_res_from_csr;
    logic                  mem_csr_we, mem_ertn, mem_excep, wb_allowin, wb_flush;
    logic [reg_addr_w-1:0] mem_rf_waddr, raddr1, raddr2, debug_wb_rf_wnum;
    logic [xlen-1:0]       mem_rf_result, mem_pc, mem_csr_wmask, mem_csr_wvalue;
    logic [xlen-1:0]       rdata1, rdata2, flush_target, debug_wb_pc, debug_wb_rf_wdata;
    logic [csr_num_w-1:0]  mem_csr_num;
    logic [ecode_w-1:0]    mem_ecode;
    logic [esubcode_w-1:0] mem_esubcode;
    logic [3:0]            debug_wb_rf_we;

    // reference state
    logic [xlen-1:0] m_regs [reg_count];
    logic [xlen-1:0] m_save [4];
    logic [xlen-1:0] m_crmd, m_prmd, m_estat, m_era, m_eentry;

    integer seed = 32'hdedc;
    int     cycles = 0;
    string  test_name;
    string  phase_names [phase_count] = '{"register commit", "bubbles", "csr access",
                                          "exception entry", "return"};
    instr_t cur;
    instr_t held;

    wb_subsystem wb_subsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(string what, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        assert (act === exp) else begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            report_failure();
        end
    endtask

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [csr_num_w-1:0] pick_csr();
        case (rnd(10))
            0: return csr_crmd;
            1: return csr_prmd;
            2: return csr_estat;
            3: return csr_era;
            4: return csr_eentry;
            5: return csr_save0;
            6: return csr_save1;
            7: return csr_save2;
            8: return csr_save3;
            // 0x100..0x1ff holds no modeled csr
            default: return csr_num_w'(14'h100 + rnd(256));
        endcase
    endfunction

    function automatic logic [xlen-1:0] writable_bits(logic [csr_num_w-1:0] num);
        case (num)
            csr_crmd:   return 32'h0000_000f;
            csr_prmd:   return 32'h0000_0007;
            csr_estat:  return 32'h0000_0003;
            csr_eentry: return 32'hffff_ffc0;
            csr_era, csr_save0, csr_save1, csr_save2, csr_save3: return '1;
            default:    return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] model_csr_read(logic [csr_num_w-1:0] num);
        case (num)
            csr_crmd:   return m_crmd;
            csr_prmd:   return m_prmd;
            csr_estat:  return m_estat;
            csr_era:    return m_era;
            csr_eentry: return m_eentry;
            csr_save0:  return m_save[0];
            csr_save1:  return m_save[1];
            csr_save2:  return m_save[2];
            csr_save3:  return m_save[3];
            default:    return '0;
        endcase
    endfunction

    task automatic model_csr_write(logic [csr_num_w-1:0] num, logic [xlen-1:0] mask,
                                   logic [xlen-1:0] value);
        logic [xlen-1:0] wr;
        logic [xlen-1:0] merged;
        wr     = mask & writable_bits(num);
        merged = (model_csr_read(num) & ~wr) | (value & wr);
        case (num)
            csr_crmd:   m_crmd   = merged;
            csr_prmd:   m_prmd   = merged;
            csr_estat:  m_estat  = merged;
            csr_era:    m_era    = merged;
            csr_eentry: m_eentry = merged;
            csr_save0:  m_save[0] = merged;
            csr_save1:  m_save[1] = merged;
            csr_save2:  m_save[2] = merged;
            csr_save3:  m_save[3] = merged;
            default: ;
        endcase
    endtask

    task automatic make_instr(int phase, output instr_t t);
        int unsigned kind;
        int unsigned pick;
        pick           = rnd(3);
        t.valid        = (phase == 0) || (rnd(phase == 1 ? 2 : 8) != 0);
        t.rf_we        = rnd(4) != 0;
        t.waddr        = (rnd(8) == 0) ? '0 : reg_addr_w'($random(seed));
        t.result       = $random(seed);
        t.pc           = $random(seed) & 32'hffff_fffc;
        t.res_from_csr = 1'b0;
        t.csr_num      = pick_csr();
        t.csr_we       = 1'b0;
        t.wmask        = $random(seed);
        t.wvalue       = $random(seed);
        t.ertn         = 1'b0;
        t.excep        = 1'b0;
        t.ecode        = (pick == 0) ? ecode_sys : (pick == 1) ? ecode_brk : ecode_ine;
        t.esubcode     = esubcode_w'($random(seed));
        // a bubble carries junk in every field
        if (!t.valid) begin
            t.res_from_csr = rnd(2);
            t.csr_we       = rnd(2);
            t.ertn         = rnd(2);
            t.excep        = rnd(2);
        end
        if (phase >= 2) begin
            kind           = rnd(4);
            t.res_from_csr = kind != 3;
            t.rf_we        = (kind != 3) || (rnd(2) == 0);
            t.csr_we       = (kind == 1) || (kind == 2);
            if (kind == 1) begin
                t.wmask = '1;
            end
        end
        if (phase == 4 && rnd(2) == 0) begin
            t.csr_num = rnd(2) ? csr_crmd : csr_prmd;
        end
        if (phase >= 3) begin
            t.excep = rnd(phase == 3 ? 4 : 6) == 0;
        end
        if (phase == 4 && rnd(5) == 0) begin
            t.ertn   = 1'b1;
            t.rf_we  = 1'b0;
            t.csr_we = 1'b0;
        end
    endtask

    task automatic drive_instr(instr_t t);
        mem_to_wb_valid  <= t.valid;
        mem_rf_we        <= t.rf_we;
        mem_rf_waddr     <= t.waddr;
        mem_rf_result    <= t.result;
        mem_pc           <= t.pc;
        mem_res_from_csr <= t.res_from_csr;
        mem_csr_num      <= t.csr_num;
        mem_csr_we       <= t.csr_we;
        mem_csr_wmask    <= t.wmask;
        mem_csr_wvalue   <= t.wvalue;
        mem_ertn         <= t.ertn;
        mem_excep        <= t.excep;
        mem_ecode        <= t.ecode;
        mem_esubcode     <= t.esubcode;
    endtask

    // t is the instruction sitting in WB this cycle
    task automatic check_and_retire(instr_t t);
        logic            commit;
        logic [xlen-1:0] wdata;
        commit = t.valid && t.rf_we && !t.excep;
        wdata  = t.res_from_csr ? model_csr_read(t.csr_num) : t.result;
        check_value("wb_allowin", 1, wb_allowin);
        check_value("rdata1", m_regs[raddr1], rdata1);
        check_value("rdata2", m_regs[raddr2], rdata2);
        check_value("debug_wb_rf_we", {4{commit}}, debug_wb_rf_we);
        check_value("wb_flush", t.valid && (t.excep || t.ertn), wb_flush);
        if (!t.valid) begin
            return;
        end
        check_value("debug_wb_pc", t.pc, debug_wb_pc);
        check_value("debug_wb_rf_wdata", wdata, debug_wb_rf_wdata);
        if (commit) begin
            check_value("debug_wb_rf_wnum", t.waddr, debug_wb_rf_wnum);
        end
        if (t.excep) begin
            check_value("flush_target", m_eentry & 32'hffff_ffc0, flush_target);
            m_prmd = '0;
            m_prmd[prmd_pplv_msb:prmd_pplv_lsb] = m_crmd[crmd_plv_msb:crmd_plv_lsb];
            m_prmd[prmd_pie] = m_crmd[crmd_ie];
            m_crmd[crmd_plv_msb:crmd_plv_lsb] = '0;
            m_crmd[crmd_ie] = 1'b0;
            m_estat[estat_ecode_msb:estat_ecode_lsb] = t.ecode;
            m_estat[estat_esubcode_msb:estat_esubcode_lsb] = t.esubcode;
            m_era = t.pc;
        end else begin
            if (t.ertn) begin
                check_value("flush_target", m_era, flush_target);
                m_crmd[crmd_plv_msb:crmd_plv_lsb] = m_prmd[prmd_pplv_msb:prmd_pplv_lsb];
                m_crmd[crmd_ie] = m_prmd[prmd_pie];
            end
            if (commit && t.waddr != '0) begin
                m_regs[t.waddr] = wdata;
            end
            if (t.csr_we) begin
                model_csr_write(t.csr_num, t.wmask, t.wvalue);
            end
        end
    endtask

    // drive on the edge, check mid cycle, accept on the next edge
    task automatic step(instr_t t);
        drive_instr(t);
        raddr1 <= reg_addr_w'($random(seed));
        raddr2 <= reg_addr_w'($random(seed));
        @(negedge clk);
        check_and_retire(held);
        held = t;
        @(posedge clk);
    endtask

    initial begin
        resetn           = 1'b0;
        mem_to_wb_valid  = 1'b0;
        mem_rf_we        = 1'b0;
        mem_rf_waddr     = '0;
        mem_rf_result    = '0;
        mem_pc           = '0;
        mem_res_from_csr = 1'b0;
        mem_csr_num      = '0;
        mem_csr_we       = 1'b0;
        mem_csr_wmask    = '0;
        mem_csr_wvalue   = '0;
        mem_ertn         = 1'b0;
        mem_excep        = 1'b0;
        mem_ecode        = '0;
        mem_esubcode     = '0;
        raddr1           = '0;
        raddr2           = '0;
        m_regs   = '{default: '0};
        m_save   = '{default: '0};
        m_crmd   = crmd_reset;
        m_prmd   = '0;
        m_estat  = '0;
        m_era    = '0;
        m_eentry = '0;
        held     = '{default: '0};
        test_name = phase_names[0];
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        for (int p = 0; p < phase_count; p++) begin
            test_name = phase_names[p];
            for (int n = 0; n < phase_len; n++) begin
                make_instr(p, cur);
                step(cur);
            end
        end
        // one bubble to retire the last instruction
        cur.valid = 1'b0;
        step(cur);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: project.f
cpu_pkg.sv
csr_pkg.sv
csr.sv
regfile.sv
wb_stage.sv
wb_subsystem.sv
tb_wb_subsystem.sv

// File: Bender.yml
package:
  name: wb_subsystem

sources:
  - files:
      - cpu_pkg.sv
      - csr_pkg.sv
      - csr.sv
      - regfile.sv
      - wb_stage.sv
      - wb_subsystem.sv
  - target: test
    files:
      - tb_wb_subsystem.sv
